/* verilog.f */
+incdir+design
design/calc_pkg.sv
design/lcd_pkg.sv
design/arith_unit.sv
design/reg_file.sv
design/lcd_formatter.sv
design/command_sequencer.sv
design/knob_calc_top.sv
tb/knob_calc_assertions.sv
tb/knob_calc_tb.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
TOP        := knob_calc_tb
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/knob_calc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module knob_calc_tb
        import calc_pkg::*;
        import lcd_pkg::*;
();

        localparam int RESET_CYCLES   = 8;
        localparam int IDLE_CLOCKS    = 3;
        // About 41 commands of up to 39 cycles each, with a wide margin
        localparam int TIMEOUT_CYCLES = 6000;

        logic                      clk;
        logic                      reset;
        logic                      rot;
        logic [`CALC_NIBBLE_W-1:0] bits;
        lcd_line_t                 line1;
        lcd_line_t                 line2;

        logic [`CALC_DATA_W-1:0]   model [`CALC_REG_COUNT];
        logic [`CALC_ADDR_W-1:0]   written [$];
        lcd_line_t                 last_exp1;
        lcd_line_t                 last_exp2;
        int                        checks;
        int                        line1_errors;
        int                        line2_errors;
        int                        timeouts;
        int                        cycle_count;

        knob_calc_top knob_calc_top_i (
                .clk   (clk),
                .reset (reset),
                .rot   (rot),
                .bits  (bits),
                .line1 (line1),
                .line2 (line2)
        );

        initial clk = 1'b0;
        always #10 clk = ~clk;

        ////////////////////////////////////////////////////////////
        // Expected display text
        ////////////////////////////////////////////////////////////

        // Leftmost character is the most significant bit
        function automatic lcd_line_t word_line(input logic [`CALC_DATA_W-1:0] w);
                lcd_line_t text;
                for (int pos = 0; pos < `LCD_CHARS; pos++)
                        text[(`LCD_CHARS-pos)*`LCD_CHAR_W-1 -: `LCD_CHAR_W] =
                                w[`CALC_DATA_W-1-pos] ? "1" : "0";
                return text;
        endfunction

        // Padding zeros on the left, address in the rightmost characters
        function automatic lcd_line_t addr_line(input logic [`CALC_ADDR_W-1:0] a);
                lcd_line_t text;
                text = {`LCD_CHARS{"0"}};
                for (int k = 0; k < `CALC_ADDR_W; k++)
                        text[k*`LCD_CHAR_W +: `LCD_CHAR_W] = a[k] ? "1" : "0";
                return text;
        endfunction

        function automatic logic [`CALC_ADDR_W-1:0] rand_addr();
                return `CALC_ADDR_W'($urandom);
        endfunction

        function automatic logic [`CALC_DATA_W-1:0] rand_word();
                return `CALC_DATA_W'($urandom);
        endfunction

        task automatic check_lines(input lcd_line_t e1, input lcd_line_t e2);
                checks++;
                last_exp1 = e1;
                last_exp2 = e2;
                line1_match: assert (line1 === e1) else begin
                        $display("Fail at %0t: line1 expected %h, got %h", $time, e1, line1);
                        line1_errors++;
                end
                line2_match: assert (line2 === e2) else begin
                        $display("Fail at %0t: line2 expected %h, got %h", $time, e2, line2);
                        line2_errors++;
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Knob stimulus
        ////////////////////////////////////////////////////////////

        // Entered and left at a falling edge
        task automatic turn(input logic [`CALC_NIBBLE_W-1:0] nibble);
                bits = nibble;
                rot  = 1'b1;
                repeat (2) @(negedge clk);
                rot  = 1'b0;
                repeat (2) @(negedge clk);
        endtask

        // Bit 3 is don't care on the opcode turn
        task automatic send_opcode(input opcode_t op);
                logic spare;
                spare = 1'($urandom);
                turn({spare, op});
        endtask

        task automatic send_addr(input logic [`CALC_ADDR_W-1:0] a);
                turn(a[3:0]);
                turn({3'b000, a[4]});
        endtask

        task automatic send_word(input logic [`CALC_DATA_W-1:0] d);
                for (int n = 0; n < 4; n++)
                        turn(d[n*`CALC_NIBBLE_W +: `CALC_NIBBLE_W]);
        endtask

        // Execute and display turns, then let the lines settle
        task automatic run_and_check(input lcd_line_t e1, input lcd_line_t e2);
                turn(4'h0);
                turn(4'h0);
                repeat (IDLE_CLOCKS) @(negedge clk);
                check_lines(e1, e2);
        endtask

        task automatic cmd_write(input logic [`CALC_ADDR_W-1:0] a,
                                 input logic [`CALC_DATA_W-1:0] d);
                send_opcode(OP_WRITE);
                send_addr(a);
                send_word(d);
                model[a] = d;
                run_and_check(addr_line(a), word_line(d));
        endtask

        task automatic cmd_read(input logic [`CALC_ADDR_W-1:0] a);
                send_opcode(OP_READ);
                send_addr(a);
                run_and_check(addr_line(a), word_line(model[a]));
        endtask

        task automatic cmd_pair(input logic [`CALC_ADDR_W-1:0] a,
                                input logic [`CALC_ADDR_W-1:0] b);
                send_opcode(OP_READ_PAIR);
                send_addr(a);
                send_addr(b);
                run_and_check(word_line(model[a]), word_line(model[b]));
        endtask

        task automatic cmd_arith(input opcode_t op, input logic [`CALC_ADDR_W-1:0] a,
                                 input logic [`CALC_ADDR_W-1:0] b,
                                 input logic [`CALC_ADDR_W-1:0] d);
                logic [`CALC_DATA_W-1:0] r;
                r = (op == OP_ADD) ? model[a] + model[b] : model[a] - model[b];
                send_opcode(op);
                send_addr(a);
                send_addr(b);
                send_addr(d);
                model[d] = r;
                run_and_check(addr_line(d), word_line(r));
        endtask

        task automatic cmd_shift(input logic [`CALC_ADDR_W-1:0] a,
                                 input logic [`CALC_ADDR_W-1:0] d,
                                 input logic [`CALC_SHAMT_W-1:0] s);
                logic [`CALC_DATA_W-1:0] r;
                r = model[a] << s;
                send_opcode(OP_SHIFT);
                send_addr(a);
                send_addr(d);
                turn(s);
                model[d] = r;
                run_and_check(addr_line(d), word_line(r));
        endtask

        task automatic finish_run();
                int bound_errors;
                bound_errors = knob_calc_top_i.knob_calc_assertions_i.failures;
                $display("%0d checks; errors %0d line1, %0d line2, %0d assertion, %0d timeout",
                         checks, line1_errors, line2_errors, bound_errors, timeouts);
                if (line1_errors + line2_errors + bound_errors + timeouts == 0)
                        $display("Simulation completed successfully");
                else
                        $display("Simulation failed");
                $finish;
        endtask

        ////////////////////////////////////////////////////////////
        // Test sequence
        ////////////////////////////////////////////////////////////

        initial begin
                logic [`CALC_ADDR_W-1:0] dst;
                void'($urandom(32'h6331));
                reset        = 1'b1;
                rot          = 1'b0;
                bits         = '0;
                checks       = 0;
                line1_errors = 0;
                line2_errors = 0;
                timeouts     = 0;
                for (int i = 0; i < `CALC_REG_COUNT; i++)
                        model[i] = '0;
                repeat (RESET_CYCLES) @(negedge clk);
                reset = 1'b0;

                check_lines('0, '0);
                cmd_read(rand_addr());
                cmd_read(rand_addr());

                repeat (8) begin
                        dst = rand_addr();
                        cmd_write(dst, rand_word());
                        written.push_back(dst);
                end
                foreach (written[i])
                        cmd_read(written[i]);

                cmd_pair(written[0], written[1]);
                cmd_pair(written[3], written[2]);
                cmd_pair(written[4], written[4]);

                dst = rand_addr();
                cmd_arith(OP_ADD, written[0], written[1], dst);
                cmd_read(dst);
                // Wrapping sum and difference
                cmd_write(5'd30, 16'hfff0);
                cmd_write(5'd31, 16'h0025);
                cmd_arith(OP_ADD, 5'd30, 5'd31, 5'd29);
                cmd_read(5'd29);
                dst = rand_addr();
                cmd_arith(OP_SUB, written[3], written[4], dst);
                cmd_read(dst);
                cmd_arith(OP_SUB, 5'd31, 5'd30, 5'd28);
                cmd_read(5'd28);

                cmd_write(5'd27, rand_word() | 16'h0001);
                cmd_shift(5'd27, 5'd26, 4'd0);
                cmd_read(5'd26);
                cmd_shift(5'd27, 5'd25, 4'd1);
                cmd_read(5'd25);
                cmd_shift(5'd27, 5'd24, 4'd15);
                cmd_read(5'd24);

                // Unused opcodes, then a fresh command right away
                turn(4'h3);
                repeat (IDLE_CLOCKS) @(negedge clk);
                check_lines(last_exp1, last_exp2);
                turn(4'hc);
                repeat (IDLE_CLOCKS) @(negedge clk);
                check_lines(last_exp1, last_exp2);
                cmd_read(written[5]);

                finish_run();
        end

        initial begin
                cycle_count = 0;
                while (cycle_count < TIMEOUT_CYCLES) begin
                        @(posedge clk);
                        cycle_count++;
                end
                timeouts++;
                $display("Timeout after %0d cycles, the run hung", cycle_count);
                finish_run();
        end

endmodule

`default_nettype wire

/* tb/knob_calc_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module knob_calc_assertions
        import lcd_pkg::*;
(
        input logic         clk,
        input logic         reset,
        input lcd_request_t lcd_req,
        input lcd_line_t    line1,
        input lcd_line_t    line2
);

        localparam int PAD_CHARS = `LCD_CHARS - `CALC_ADDR_W;
        localparam int LINE_W    = `LCD_CHARS * `LCD_CHAR_W;

        logic shown;
        int   failures = 0;

        function automatic logic all_digits(input lcd_line_t text);
                logic ok;
                logic [`LCD_CHAR_W-1:0] ch;
                ok = 1'b1;
                for (int i = 0; i < `LCD_CHARS; i++) begin
                        ch = text[i*`LCD_CHAR_W +: `LCD_CHAR_W];
                        if (ch != `LCD_ASCII_ZERO && ch != `LCD_ASCII_ONE)
                                ok = 1'b0;
                end
                return ok;
        endfunction

        // Set by the edge that loads the first request
        always_ff @(posedge clk) begin
                if (reset)
                        shown <= 1'b0;
                else if (lcd_req.valid)
                        shown <= 1'b1;
        end

        ////////////////////////////////////////////////////////////
        // Display checks
        ////////////////////////////////////////////////////////////

        lines_hold: assert property (@(posedge clk) disable iff (reset)
                !$past(lcd_req.valid) |-> ($stable(line1) && $stable(line2)))
                else begin
                        $error("display lines changed without a request");
                        failures++;
                end

        valid_pulse: assert property (@(posedge clk) disable iff (reset)
                lcd_req.valid |=> !lcd_req.valid)
                else begin
                        $error("request valid held longer than one clock");
                        failures++;
                end

        chars_binary: assert property (@(posedge clk) disable iff (reset)
                shown |-> (all_digits(line1) && all_digits(line2)))
                else begin
                        $error("display holds a character other than 0 or 1");
                        failures++;
                end

        addr_pad: assert property (@(posedge clk) disable iff (reset)
                $past(lcd_req.valid && lcd_req.mode == MODE_ADDR_DATA) |->
                (line1[LINE_W-1 -: PAD_CHARS*`LCD_CHAR_W] == {PAD_CHARS{`LCD_ASCII_ZERO}}))
                else begin
                        $error("address line padding is not all zero characters");
                        failures++;
                end

endmodule

bind knob_calc_top knob_calc_assertions knob_calc_assertions_i (
        .clk     (clk),
        .reset   (reset),
        .lcd_req (lcd_req),
        .line1   (line1),
        .line2   (line2)
);

`default_nettype wire

/* design/knob_calc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module knob_calc_top
        import calc_pkg::*;
        import lcd_pkg::*;
(
        input  logic                      clk,
        input  logic                      reset,
        input  logic                      rot,
        input  logic [`CALC_NIBBLE_W-1:0] bits,
        output lcd_line_t                 line1,
        output lcd_line_t                 line2
);

        logic [`CALC_ADDR_W-1:0]  rd_addr_a;
        logic [`CALC_ADDR_W-1:0]  rd_addr_b;
        logic [`CALC_DATA_W-1:0]  rd_data_a;
        logic [`CALC_DATA_W-1:0]  rd_data_b;
        logic [`CALC_DATA_W-1:0]  operand_a;
        logic [`CALC_DATA_W-1:0]  operand_b;
        logic [`CALC_DATA_W-1:0]  alu_result;
        logic [`CALC_SHAMT_W-1:0] shamt;
        alu_op_t                  alu_op;
        reg_write_t               wr;
        lcd_request_t             lcd_req;

        command_sequencer command_sequencer_i (
                .clk        (clk),
                .reset      (reset),
                .rot        (rot),
                .bits       (bits),
                .rd_data_a  (rd_data_a),
                .rd_data_b  (rd_data_b),
                .alu_result (alu_result),
                .rd_addr_a  (rd_addr_a),
                .rd_addr_b  (rd_addr_b),
                .operand_a  (operand_a),
                .operand_b  (operand_b),
                .shamt      (shamt),
                .alu_op     (alu_op),
                .wr         (wr),
                .lcd_req    (lcd_req)
        );

        reg_file reg_file_i (
                .clk       (clk),
                .reset     (reset),
                .rd_addr_a (rd_addr_a),
                .rd_addr_b (rd_addr_b),
                .wr        (wr),
                .rd_data_a (rd_data_a),
                .rd_data_b (rd_data_b)
        );

        arith_unit arith_unit_i (
                .operand_a (operand_a),
                .operand_b (operand_b),
                .shamt     (shamt),
                .alu_op    (alu_op),
                .result    (alu_result)
        );

        lcd_formatter lcd_formatter_i (
                .clk     (clk),
                .reset   (reset),
                .lcd_req (lcd_req),
                .line1   (line1),
                .line2   (line2)
        );

endmodule

`default_nettype wire

/* design/command_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module command_sequencer
        import calc_pkg::*;
        import lcd_pkg::*;
(
        input  logic                     clk,
        input  logic                     reset,
        input  logic                     rot,
        input  logic [`CALC_NIBBLE_W-1:0] bits,
        input  logic [`CALC_DATA_W-1:0]  rd_data_a,
        input  logic [`CALC_DATA_W-1:0]  rd_data_b,
        input  logic [`CALC_DATA_W-1:0]  alu_result,
        output logic [`CALC_ADDR_W-1:0]  rd_addr_a,
        output logic [`CALC_ADDR_W-1:0]  rd_addr_b,
        output logic [`CALC_DATA_W-1:0]  operand_a,
        output logic [`CALC_DATA_W-1:0]  operand_b,
        output logic [`CALC_SHAMT_W-1:0] shamt,
        output alu_op_t                  alu_op,
        output reg_write_t               wr,
        output lcd_request_t             lcd_req
);

        // Operand fields filled by nibble turns
        localparam logic [2:0] F_ADDR_A = 3'd0;
        localparam logic [2:0] F_ADDR_B = 3'd1;
        localparam logic [2:0] F_DST    = 3'd2;
        localparam logic [2:0] F_DATA   = 3'd3;
        localparam logic [2:0] F_SHAMT  = 3'd4;

        logic                    rot_q;
        logic                    turn;
        seq_state_t              state;
        opcode_t                 opcode;
        logic [1:0]              field_idx;
        logic [1:0]              nibble;
        logic [2:0]              cur_field;
        logic [1:0]              last_nib;
        logic                    is_alu;
        logic [`CALC_ADDR_W-1:0] addr_a;
        logic [`CALC_ADDR_W-1:0] addr_b;
        logic [`CALC_ADDR_W-1:0] dst;
        logic [`CALC_DATA_W-1:0] data;
        lcd_request_t            next_req;

        ////////////////////////////////////////////////////////////
        // Operand table
        ////////////////////////////////////////////////////////////

        function automatic logic [2:0] field_code(opcode_t op, logic [1:0] idx);
                logic [2:0] code;
                code = F_ADDR_A;
                case (op)
                        OP_WRITE:     code = (idx == 2'd0) ? F_DST : F_DATA;
                        OP_READ_PAIR: code = (idx == 2'd0) ? F_ADDR_A : F_ADDR_B;
                        OP_ADD, OP_SUB: begin
                                if (idx == 2'd1)
                                        code = F_ADDR_B;
                                else if (idx == 2'd2)
                                        code = F_DST;
                        end
                        OP_SHIFT: begin
                                if (idx == 2'd1)
                                        code = F_DST;
                                else if (idx == 2'd2)
                                        code = F_SHAMT;
                        end
                        default: code = F_ADDR_A;
                endcase
                return code;
        endfunction

        function automatic logic [1:0] last_field(opcode_t op);
                logic [1:0] last;
                case (op)
                        OP_READ:                  last = 2'd0;
                        OP_WRITE, OP_READ_PAIR:   last = 2'd1;
                        default:                  last = 2'd2;
                endcase
                return last;
        endfunction

        function automatic logic [1:0] last_nibble(logic [2:0] code);
                logic [1:0] last;
                case (code)
                        F_DATA:  last = 2'd3;
                        F_SHAMT: last = 2'd0;
                        default: last = 2'd1;
                endcase
                return last;
        endfunction

        // Low nibble first, then the top address bit
        function automatic logic [`CALC_ADDR_W-1:0] load_addr(
                logic [`CALC_ADDR_W-1:0]   cur,
                logic [1:0]                nib,
                logic [`CALC_NIBBLE_W-1:0] value);
                logic [`CALC_ADDR_W-1:0] next;
                next = cur;
                if (nib == 2'd0)
                        next[`CALC_NIBBLE_W-1:0] = value;
                else
                        next[`CALC_ADDR_W-1] = value[0];
                return next;
        endfunction

        assign turn      = rot & ~rot_q;
        assign cur_field = field_code(opcode, field_idx);
        assign last_nib  = last_nibble(cur_field);
        assign is_alu    = (opcode == OP_ADD) || (opcode == OP_SUB) || (opcode == OP_SHIFT);

        assign rd_addr_a = addr_a;
        assign rd_addr_b = addr_b;

        ////////////////////////////////////////////////////////////
        // Control
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        rot_q     <= 1'b0;
                        state     <= IDLE;
                        opcode    <= OP_WRITE;
                        field_idx <= '0;
                        nibble    <= '0;
                        lcd_req   <= '0;
                end else begin
                        rot_q         <= rot;
                        lcd_req.valid <= 1'b0;
                        if (turn) begin
                                case (state)
                                        IDLE: begin
                                                if (bits[2:0] inside {OP_WRITE, OP_READ,
                                                                OP_READ_PAIR, OP_ADD,
                                                                OP_SUB, OP_SHIFT}) begin
                                                        opcode    <= opcode_t'(bits[2:0]);
                                                        field_idx <= '0;
                                                        nibble    <= '0;
                                                        state     <= COLLECT;
                                                end
                                        end
                                        COLLECT: begin
                                                if (nibble == last_nib) begin
                                                        nibble <= '0;
                                                        if (field_idx == last_field(opcode))
                                                                state <= EXECUTE;
                                                        else
                                                                field_idx <= field_idx + 2'd1;
                                                end else begin
                                                        nibble <= nibble + 2'd1;
                                                end
                                        end
                                        EXECUTE: state <= DISPLAY;
                                        DISPLAY: begin
                                                lcd_req <= next_req;
                                                state   <= IDLE;
                                        end
                                        default: state <= IDLE;
                                endcase
                        end
                end
        end

        // Operand fields and latched read data
        always_ff @(posedge clk) begin
                if (turn && state == COLLECT) begin
                        case (cur_field)
                                F_ADDR_A: addr_a <= load_addr(addr_a, nibble, bits);
                                F_ADDR_B: addr_b <= load_addr(addr_b, nibble, bits);
                                F_DST:    dst    <= load_addr(dst, nibble, bits);
                                F_DATA:   data[nibble*`CALC_NIBBLE_W +: `CALC_NIBBLE_W] <= bits;
                                F_SHAMT:  shamt  <= bits;
                                default: ;
                        endcase
                end
                if (turn && state == EXECUTE) begin
                        operand_a <= rd_data_a;
                        operand_b <= rd_data_b;
                end
        end

        always_comb begin
                case (opcode)
                        OP_SUB:   alu_op = ALU_SUB;
                        OP_SHIFT: alu_op = ALU_SHL;
                        default:  alu_op = ALU_ADD;
                endcase
        end

        // Write goes out on the EXECUTE turn, ALU result on the DISPLAY turn
        always_comb begin
                wr.addr = dst;
                wr.data = (state == EXECUTE) ? data : alu_result;
                wr.en   = turn && (((state == EXECUTE) && (opcode == OP_WRITE)) ||
                                   ((state == DISPLAY) && is_alu));
        end

        always_comb begin
                next_req.valid  = 1'b1;
                next_req.mode   = MODE_ADDR_DATA;
                next_req.addr   = dst;
                next_req.data_a = alu_result;
                next_req.data_b = operand_b;
                case (opcode)
                        OP_WRITE: next_req.data_a = data;
                        OP_READ: begin
                                next_req.addr   = addr_a;
                                next_req.data_a = operand_a;
                        end
                        OP_READ_PAIR: begin
                                next_req.mode   = MODE_DATA_PAIR;
                                next_req.data_a = operand_a;
                        end
                        default: ;
                endcase
        end

endmodule

`default_nettype wire

/* design/lcd_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module lcd_formatter
        import lcd_pkg::*;
(
        input  logic         clk,
        input  logic         reset,
        input  lcd_request_t lcd_req,
        output lcd_line_t    line1,
        output lcd_line_t    line2
);

        logic [`CALC_DATA_W-1:0] word1;
        logic [`CALC_DATA_W-1:0] word2;
        lcd_line_t               text1;
        lcd_line_t               text2;

        // Address mode pads the address to a full word of leading zeros
        always_comb begin
                if (lcd_req.mode == MODE_ADDR_DATA) begin
                        word1 = {{(`CALC_DATA_W-`CALC_ADDR_W){1'b0}}, lcd_req.addr};
                        word2 = lcd_req.data_a;
                end else begin
                        word1 = lcd_req.data_a;
                        word2 = lcd_req.data_b;
                end
        end

        ////////////////////////////////////////////////////////////
        // One character per bit, MSB leftmost
        ////////////////////////////////////////////////////////////

        for (genvar i = 0; i < `LCD_CHARS; i++) begin : g_char
                assign text1[i*`LCD_CHAR_W +: `LCD_CHAR_W] =
                        word1[i] ? `LCD_ASCII_ONE : `LCD_ASCII_ZERO;
                assign text2[i*`LCD_CHAR_W +: `LCD_CHAR_W] =
                        word2[i] ? `LCD_ASCII_ONE : `LCD_ASCII_ZERO;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        line1 <= '0;
                        line2 <= '0;
                end else if (lcd_req.valid) begin
                        line1 <= text1;
                        line2 <= text2;
                end
        end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module reg_file
        import calc_pkg::*;
(
        input  logic                    clk,
        input  logic                    reset,
        input  logic [`CALC_ADDR_W-1:0] rd_addr_a,
        input  logic [`CALC_ADDR_W-1:0] rd_addr_b,
        input  reg_write_t              wr,
        output logic [`CALC_DATA_W-1:0] rd_data_a,
        output logic [`CALC_DATA_W-1:0] rd_data_b
);

        logic [`CALC_DATA_W-1:0] regs [`CALC_REG_COUNT];

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < `CALC_REG_COUNT; i++)
                                regs[i] <= '0;
                end else if (wr.en) begin
                        regs[wr.addr] <= wr.data;
                end
        end

        // Asynchronous read ports
        assign rd_data_a = regs[rd_addr_a];
        assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

/* design/arith_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module arith_unit
        import calc_pkg::*;
(
        input  logic [`CALC_DATA_W-1:0]  operand_a,
        input  logic [`CALC_DATA_W-1:0]  operand_b,
        input  logic [`CALC_SHAMT_W-1:0] shamt,
        input  alu_op_t                  alu_op,
        output logic [`CALC_DATA_W-1:0]  result
);

        // Sums wrap at 16 bits, shift fills with zeros
        always_comb begin
                case (alu_op)
                        ALU_ADD: result = operand_a + operand_b;
                        ALU_SUB: result = operand_a - operand_b;
                        ALU_SHL: result = operand_a << shamt;
                        default: result = operand_a + operand_b;
                endcase
        end

endmodule

`default_nettype wire

/* design/lcd_pkg.sv */
`default_nettype none

`include "calc_defines.svh"

package lcd_pkg;

        typedef logic [`LCD_CHARS*`LCD_CHAR_W-1:0] lcd_line_t;

        // Address plus data, or two data words
        typedef enum logic {
                MODE_ADDR_DATA,
                MODE_DATA_PAIR
        } lcd_mode_t;

        typedef struct packed {
                logic                    valid;
                lcd_mode_t               mode;
                logic [`CALC_ADDR_W-1:0] addr;
                logic [`CALC_DATA_W-1:0] data_a;
                logic [`CALC_DATA_W-1:0] data_b;
        } lcd_request_t;

endpackage

`default_nettype wire

/* design/calc_pkg.sv */
`default_nettype none

`include "calc_defines.svh"

package calc_pkg;

        // Three-bit command codes, 3 and 4 unused
        typedef enum logic [2:0] {
                OP_WRITE     = 3'd0,
                OP_READ      = 3'd1,
                OP_READ_PAIR = 3'd2,
                OP_ADD       = 3'd5,
                OP_SUB       = 3'd6,
                OP_SHIFT     = 3'd7
        } opcode_t;

        typedef enum logic [1:0] {
                IDLE,
                COLLECT,
                EXECUTE,
                DISPLAY
        } seq_state_t;

        typedef enum logic [1:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_SHL
        } alu_op_t;

        // One write-port command
        typedef struct packed {
                logic                    en;
                logic [`CALC_ADDR_W-1:0] addr;
                logic [`CALC_DATA_W-1:0] data;
        } reg_write_t;

endpackage

`default_nettype wire

/* design/calc_defines.svh */
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

////////////////////////////////////////////////////////////
// Register file and operand widths
////////////////////////////////////////////////////////////

`define CALC_DATA_W     16
`define CALC_ADDR_W     5
`define CALC_REG_COUNT  32
`define CALC_NIBBLE_W   4
`define CALC_SHAMT_W    4

////////////////////////////////////////////////////////////
// Character display
////////////////////////////////////////////////////////////

`define LCD_CHARS       16
`define LCD_CHAR_W      8
`define LCD_ASCII_ZERO  8'h30
`define LCD_ASCII_ONE   8'h31

`endif
